// File: logic/rv32Pkg.sv
package rv32Pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [15:0] mgmtAddr_t;
	typedef logic [3:0] byteSel_t;

	typedef enum logic {
		stateHalt    = 1'b0,
		stateExecute = 1'b1
	} coreState_e;

	// Major opcodes of the supported subset
	localparam logic [6:0] opLui   = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opImm   = 7'b0010011;
	localparam logic [6:0] opReg   = 7'b0110011;

	// Management address map
	localparam mgmtAddr_t mgmtPcSet   = 16'h0000;
	localparam mgmtAddr_t mgmtPcStep  = 16'h0008;
	localparam mgmtAddr_t mgmtStatus  = 16'h0020;
	localparam mgmtAddr_t mgmtRegBase = 16'h4000;

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t instruction;
	} fetchPacket_t;

	typedef struct packed {
		logic     enable;
		regAddr_t rd;
		word_t    data;
	} writeback_t;

	typedef struct packed {
		logic      writeEnable;
		byteSel_t  byteSelect;
		mgmtAddr_t address;
		word_t     writeData;
	} mgmtRequest_t;

endpackage

// File: logic/managementPort.sv
`timescale 1ns/1ps

module managementPort (
	input  logic                  clk,
	input  logic                  rst,
	input  rv32Pkg::mgmtRequest_t mgmt,
	input  logic                  halted,
	input  rv32Pkg::word_t        fetchPc,
	input  logic                  invalidSeen,
	input  rv32Pkg::word_t        regReadData,
	output rv32Pkg::regAddr_t     regReadAddr,
	output rv32Pkg::writeback_t   regWrite,
	output logic                  pcSet,
	output rv32Pkg::word_t        pcSetValue,
	output logic                  stepRequest,
	output rv32Pkg::word_t        readData
);
	import rv32Pkg::*;

	logic selPc;
	logic selStep;
	logic selStatus;
	logic selReg;
	logic writeValid;
	logic errorFlag;
	word_t rawData;

	assign selPc = mgmt.address == mgmtPcSet;
	assign selStep = mgmt.address == mgmtPcStep;
	assign selStatus = mgmt.address == mgmtStatus;
	// One aligned word per register, x0 to x31
	assign selReg = (mgmt.address & ~16'h007c) == mgmtRegBase;
	assign writeValid = halted && mgmt.writeEnable;

	assign regReadAddr = mgmt.address[6:2];
	assign regWrite.enable = writeValid && selReg;
	assign regWrite.rd = mgmt.address[6:2];
	assign regWrite.data = mgmt.writeData;

	assign pcSet = writeValid && selPc;
	assign pcSetValue = mgmt.writeData;
	assign stepRequest = writeValid && selStep;

	// Sticky until cleared through the status word
	always_ff @(posedge clk) begin
		if (rst) begin
			errorFlag <= 1'b0;
		end else if (invalidSeen) begin
			errorFlag <= 1'b1;
		end else if (writeValid && selStatus) begin
			errorFlag <= 1'b0;
		end
	end

	always_comb begin
		if (selPc) begin
			rawData = fetchPc;
		end else if (selStatus) begin
			rawData = {31'b0, errorFlag};
		end else if (selReg) begin
			rawData = (regReadAddr == '0) ? '0 : regReadData;
		end else begin
			rawData = '1;
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			readData[8*i +: 8] = mgmt.byteSelect[i] ? rawData[8*i +: 8] : 8'h00;
		end
	end

endmodule

// File: logic/instructionFetch.sv
`timescale 1ns/1ps

module instructionFetch #(
	parameter rv32Pkg::word_t resetVector = 32'h0000_0000
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stepPipe,
	input  logic                  fetchAllowed,
	input  logic                  pcSet,
	input  rv32Pkg::word_t        pcSetValue,
	output rv32Pkg::word_t        instrAddress,
	output logic                  instrEnable,
	input  rv32Pkg::word_t        instrData,
	output rv32Pkg::word_t        fetchPc,
	output rv32Pkg::fetchPacket_t packet
);

	logic requestActive;
	logic accepted;

	assign accepted = requestActive && stepPipe;
	assign instrEnable = requestActive;
	assign instrAddress = fetchPc;

	// Request only moves while the pipe steps, so it holds under busy
	always_ff @(posedge clk) begin
		if (rst) begin
			requestActive <= 1'b0;
		end else if (stepPipe) begin
			requestActive <= fetchAllowed;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fetchPc <= resetVector;
		end else if (pcSet) begin
			fetchPc <= pcSetValue;
		end else if (accepted) begin
			fetchPc <= fetchPc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			packet.valid <= 1'b0;
		end else if (stepPipe) begin
			packet.valid <= requestActive;
		end
		if (stepPipe) begin
			packet.pc <= fetchPc;
			packet.instruction <= instrData;
		end
	end

endmodule

// File: logic/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stepPipe,
	input  rv32Pkg::fetchPacket_t packet,
	output rv32Pkg::regAddr_t     rs1Addr,
	output rv32Pkg::regAddr_t     rs2Addr,
	input  rv32Pkg::word_t        rs1Data,
	input  rv32Pkg::word_t        rs2Data,
	output rv32Pkg::writeback_t   writeback,
	output logic                  invalidSeen,
	output logic                  busy
);
	import rv32Pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	regAddr_t rd;
	word_t immI;
	word_t immU;
	word_t operandB;
	word_t aluResult;
	word_t result;
	logic [4:0] shamt;
	logic legal;
	logic wbValid;

	assign opcode = packet.instruction[6:0];
	assign rd = packet.instruction[11:7];
	assign funct3 = packet.instruction[14:12];
	assign funct7 = packet.instruction[31:25];
	assign rs1Addr = packet.instruction[19:15];
	assign rs2Addr = packet.instruction[24:20];

	assign immI = {{20{packet.instruction[31]}}, packet.instruction[31:20]};
	assign immU = {packet.instruction[31:12], 12'h000};
	assign operandB = (opcode == opReg) ? rs2Data : immI;
	assign shamt = operandB[4:0];

	always_comb begin
		case (funct3)
			3'b000: begin
				// Only the register form has a subtract
				if (opcode == opReg && funct7[5]) begin
					aluResult = rs1Data - operandB;
				end else begin
					aluResult = rs1Data + operandB;
				end
			end
			3'b001: aluResult = rs1Data << shamt;
			3'b010: aluResult = {31'b0, $signed(rs1Data) < $signed(operandB)};
			3'b011: aluResult = {31'b0, rs1Data < operandB};
			3'b100: aluResult = rs1Data ^ operandB;
			3'b101: begin
				if (funct7[5]) begin
					aluResult = $signed(rs1Data) >>> shamt;
				end else begin
					aluResult = rs1Data >> shamt;
				end
			end
			3'b110: aluResult = rs1Data | operandB;
			default: aluResult = rs1Data & operandB;
		endcase
	end

	always_comb begin
		case (opcode)
			opLui: result = immU;
			opAuipc: result = packet.pc + immU;
			default: result = aluResult;
		endcase
	end

	// Shift immediates and the register group constrain funct7
	always_comb begin
		case (opcode)
			opLui, opAuipc: legal = 1'b1;
			opImm: begin
				if (funct3 == 3'b001) begin
					legal = funct7 == 7'h00;
				end else if (funct3 == 3'b101) begin
					legal = funct7 == 7'h00 || funct7 == 7'h20;
				end else begin
					legal = 1'b1;
				end
			end
			opReg: legal = funct7 == 7'h00 ||
				(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
			default: legal = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			writeback.enable <= 1'b0;
			wbValid <= 1'b0;
		end else if (stepPipe) begin
			writeback.enable <= packet.valid && legal;
			wbValid <= packet.valid;
		end
		if (stepPipe) begin
			writeback.rd <= rd;
			writeback.data <= result;
		end
	end

	assign invalidSeen = stepPipe && packet.valid && !legal;
	assign busy = packet.valid || wbValid;

endmodule

// File: logic/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic                clk,
	input  rv32Pkg::writeback_t pipeWrite,
	input  rv32Pkg::writeback_t mgmtWrite,
	input  rv32Pkg::regAddr_t   rs1Addr,
	input  rv32Pkg::regAddr_t   rs2Addr,
	input  rv32Pkg::regAddr_t   mgmtAddr,
	output rv32Pkg::word_t      rs1Data,
	output rv32Pkg::word_t      rs2Data,
	output rv32Pkg::word_t      mgmtData
);
	import rv32Pkg::*;

	// No storage behind x0
	word_t regs [1:31];

	function automatic word_t readOperand(input regAddr_t addr);
		if (addr == '0) begin
			return '0;
		end
		// Bypass the write landing on this edge
		if (pipeWrite.enable && pipeWrite.rd == addr) begin
			return pipeWrite.data;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (pipeWrite.enable && pipeWrite.rd != '0) begin
			regs[pipeWrite.rd] <= pipeWrite.data;
		end else if (mgmtWrite.enable && mgmtWrite.rd != '0) begin
			regs[mgmtWrite.rd] <= mgmtWrite.data;
		end
	end

	always_comb begin
		rs1Data = readOperand(rs1Addr);
		rs2Data = readOperand(rs2Addr);
		mgmtData = (mgmtAddr == '0) ? '0 : regs[mgmtAddr];
	end

endmodule

// File: logic/rv32Core.sv
`timescale 1ns/1ps

module rv32Core #(
	parameter rv32Pkg::word_t resetVector = 32'h0000_0000
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  run,
	input  rv32Pkg::mgmtRequest_t mgmt,
	output rv32Pkg::word_t        mgmtReadData,
	output rv32Pkg::word_t        instrAddress,
	output logic                  instrEnable,
	input  rv32Pkg::word_t        instrData,
	input  logic                  instrBusy,
	output rv32Pkg::coreState_e   probeState,
	output rv32Pkg::word_t        probeProgramCounter
);
	import rv32Pkg::*;

	coreState_e state;
	logic stepPending;
	logic stepPipe;
	logic fetchAllowed;
	logic halted;
	logic pipeBusy;
	logic pcSet;
	logic stepRequest;
	logic invalidSeen;
	word_t pcSetValue;
	word_t fetchPc;
	word_t regReadData;
	word_t rs1Data;
	word_t rs2Data;
	regAddr_t regReadAddr;
	regAddr_t rs1Addr;
	regAddr_t rs2Addr;
	writeback_t mgmtWrite;
	writeback_t pipeWrite;
	fetchPacket_t fetchPacket;

	assign stepPipe = (state == stateExecute) && !instrBusy;
	assign halted = (state == stateHalt) && !run;
	// A step allows fetching only until its request is raised
	assign fetchAllowed = run || (stepPending && !instrEnable);

	always_ff @(posedge clk) begin
		if (rst) begin
			stepPending <= 1'b0;
		end else if (stepRequest) begin
			stepPending <= 1'b1;
		end else if (instrEnable && stepPipe) begin
			stepPending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateHalt;
		end else begin
			case (state)
				stateHalt: begin
					if (run || stepRequest) begin
						state <= stateExecute;
					end
				end
				default: begin
					// Drained and nothing more to fetch
					if (!instrEnable && !fetchAllowed && !pipeBusy) begin
						state <= stateHalt;
					end
				end
			endcase
		end
	end

	managementPort u_managementPort (
		.clk(clk),
		.rst(rst),
		.mgmt(mgmt),
		.halted(halted),
		.fetchPc(fetchPc),
		.invalidSeen(invalidSeen),
		.regReadData(regReadData),
		.regReadAddr(regReadAddr),
		.regWrite(mgmtWrite),
		.pcSet(pcSet),
		.pcSetValue(pcSetValue),
		.stepRequest(stepRequest),
		.readData(mgmtReadData)
	);

	instructionFetch #(
		.resetVector(resetVector)
	) u_instructionFetch (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.fetchAllowed(fetchAllowed),
		.pcSet(pcSet),
		.pcSetValue(pcSetValue),
		.instrAddress(instrAddress),
		.instrEnable(instrEnable),
		.instrData(instrData),
		.fetchPc(fetchPc),
		.packet(fetchPacket)
	);

	executeStage u_executeStage (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.packet(fetchPacket),
		.rs1Addr(rs1Addr),
		.rs2Addr(rs2Addr),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.writeback(pipeWrite),
		.invalidSeen(invalidSeen),
		.busy(pipeBusy)
	);

	registerFile u_registerFile (
		.clk(clk),
		.pipeWrite(pipeWrite),
		.mgmtWrite(mgmtWrite),
		.rs1Addr(rs1Addr),
		.rs2Addr(rs2Addr),
		.mgmtAddr(regReadAddr),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.mgmtData(regReadData)
	);

	assign probeState = state;
	assign probeProgramCounter = fetchPc;

endmodule

// File: sim/rv32Core_assertions.sv
`timescale 1ns/1ps

module rv32CoreAssertions (
	input logic                  clk,
	input logic                  rst,
	input rv32Pkg::coreState_e   state,
	input logic                  stepPending,
	input logic                  instrEnable,
	input logic                  instrBusy,
	input rv32Pkg::word_t        instrAddress,
	input rv32Pkg::mgmtRequest_t mgmt,
	input rv32Pkg::writeback_t   pipeWrite,
	input rv32Pkg::word_t        regs [1:31]
);
	import rv32Pkg::*;

	int failCount = 0;
	regAddr_t target;
	logic targetWrite;
	logic watchTarget;
	regAddr_t watchedReg;
	word_t watchedValue;

	assign target = mgmt.address[6:2];
	// Register write request that the pipe does not hit on the same edge
	assign targetWrite = mgmt.writeEnable && target != '0 &&
		mgmt.address[15:7] == mgmtRegBase[15:7] && mgmt.address[1:0] == 2'b00 &&
		!(pipeWrite.enable && pipeWrite.rd == target);

	always_ff @(posedge clk) begin
		watchTarget <= state == stateExecute && targetWrite;
		watchedReg <= target;
		watchedValue <= (target == '0) ? '0 : regs[target];
	end

	busyHold: assert property (@(posedge clk) disable iff (rst)
		instrEnable && instrBusy |=> instrEnable && $stable(instrAddress))
	else begin
		failCount = failCount + 1;
		$error("fetch request changed while instrBusy was high");
	end

	// Nothing is fetched from halt unless a step is pending
	haltQuiet: assert property (@(posedge clk) disable iff (rst)
		state == stateHalt && !stepPending |-> !instrEnable)
	else begin
		failCount = failCount + 1;
		$error("instrEnable high while halted with no step pending");
	end

	// Targeted register keeps its old value
	mgmtBlocked: assert property (@(posedge clk) disable iff (rst)
		watchTarget |-> regs[watchedReg] == watchedValue)
	else begin
		failCount = failCount + 1;
		$error("management write took effect while executing");
	end

endmodule

bind rv32Core rv32CoreAssertions u_rv32CoreAssertions (
	.clk(clk),
	.rst(rst),
	.state(state),
	.stepPending(stepPending),
	.instrEnable(instrEnable),
	.instrBusy(instrBusy),
	.instrAddress(instrAddress),
	.mgmt(mgmt),
	.pipeWrite(pipeWrite),
	.regs(u_registerFile.regs)
);

// File: sim/coreChecker.sv
`timescale 1ns/1ps

module coreChecker #(
	parameter rv32Pkg::word_t resetVector = 32'h0000_0000
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  run,
	input  rv32Pkg::mgmtRequest_t mgmt,
	input  rv32Pkg::word_t        mgmtReadData,
	input  rv32Pkg::word_t        instrAddress,
	input  logic                  instrEnable,
	input  rv32Pkg::word_t        instrData,
	input  logic                  instrBusy,
	input  rv32Pkg::coreState_e   probeState,
	input  rv32Pkg::word_t        probeProgramCounter,
	output int                    errorCount,
	output int                    readChecks,
	output int                    acceptedFetches
);
	import rv32Pkg::*;

	word_t modelRegs [0:31];
	word_t modelPc;
	logic modelError;
	logic stepActive;
	int stepFetches;

	function automatic logic isLegal(input word_t ins);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = ins[14:12];
		f7 = ins[31:25];
		if (ins[6:0] == opLui || ins[6:0] == opAuipc) begin
			return 1'b1;
		end
		if (ins[6:0] == opImm) begin
			if (f3 == 3'b001) begin
				return f7 == 7'h00;
			end
			return f3 != 3'b101 || f7 == 7'h00 || f7 == 7'h20;
		end
		if (ins[6:0] == opReg) begin
			return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
		end
		return 1'b0;
	endfunction

	function automatic word_t aluOp(input word_t ins, input word_t a, input word_t b);
		logic [4:0] sh;
		sh = b[4:0];
		case (ins[14:12])
			3'b000: return (ins[6:0] == opReg && ins[30]) ? a - b : a + b;
			3'b001: return a << sh;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (ins[30]) begin
					return $signed(a) >>> sh;
				end
				return a >> sh;
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic word_t modelRead(input mgmtAddr_t addr);
		if (addr == mgmtPcSet) begin
			return modelPc;
		end
		if (addr == mgmtStatus) begin
			return {31'b0, modelError};
		end
		if (addr[15:7] == mgmtRegBase[15:7] && addr[1:0] == 2'b00) begin
			return modelRegs[addr[6:2]];
		end
		return '1;
	endfunction

	function automatic word_t applyMask(input word_t value, input byteSel_t mask);
		word_t masked;
		masked = value;
		for (int i = 0; i < 4; i++) begin
			if (!mask[i]) begin
				masked[8*i +: 8] = 8'h00;
			end
		end
		return masked;
	endfunction

	task automatic checkRead();
		word_t expected;
		expected = applyMask(modelRead(mgmt.address), mgmt.byteSelect);
		readChecks++;
		if (mgmtReadData !== expected) begin
			errorCount++;
			$display("error mgmtReadData at %h: expected %h, got %h",
				mgmt.address, expected, mgmtReadData);
		end
	endtask

	task automatic retire(input word_t pc, input word_t ins);
		word_t immI;
		word_t immU;
		word_t value;
		if (pc !== modelPc) begin
			errorCount++;
			$display("error instrAddress: expected %h, got %h", modelPc, pc);
		end
		immI = {{20{ins[31]}}, ins[31:20]};
		immU = {ins[31:12], 12'h000};
		if (!isLegal(ins)) begin
			modelError = 1'b1;
		end else begin
			case (ins[6:0])
				opLui: value = immU;
				opAuipc: value = modelPc + immU;
				opReg: value = aluOp(ins, modelRegs[ins[19:15]], modelRegs[ins[24:20]]);
				default: value = aluOp(ins, modelRegs[ins[19:15]], immI);
			endcase
			if (ins[11:7] != 5'd0) begin
				modelRegs[ins[11:7]] = value;
			end
		end
		modelPc = modelPc + 32'd4;
		acceptedFetches++;
		if (stepActive) begin
			stepFetches++;
		end
	endtask

	task automatic applyWrite();
		if (mgmt.address == mgmtPcSet) begin
			modelPc = mgmt.writeData;
		end else if (mgmt.address == mgmtStatus) begin
			modelError = 1'b0;
		end else if (mgmt.address == mgmtPcStep) begin
			stepActive = 1'b1;
			stepFetches = 0;
		end else if (mgmt.address[15:7] == mgmtRegBase[15:7] && mgmt.address[1:0] == 2'b00) begin
			if (mgmt.address[6:2] != 5'd0) begin
				modelRegs[mgmt.address[6:2]] = mgmt.writeData;
			end
		end
	endtask

	// Samples are taken before this edge's updates land
	always @(posedge clk) begin
		if (rst) begin
			modelRegs[0] = '0;
			modelPc = resetVector;
			modelError = 1'b0;
			stepActive = 1'b0;
			stepFetches = 0;
			errorCount = 0;
			readChecks = 0;
			acceptedFetches = 0;
		end else begin
			if (probeProgramCounter !== modelPc) begin
				errorCount++;
				$display("error probeProgramCounter: expected %h, got %h",
					modelPc, probeProgramCounter);
			end
			if (probeState == stateHalt && !run && !mgmt.writeEnable && mgmt.byteSelect != '0) begin
				checkRead();
			end
			if (stepActive && probeState == stateHalt) begin
				if (stepFetches != 1) begin
					errorCount++;
					$display("error step fetch count: expected %h, got %h", 1, stepFetches);
				end
				stepActive = 1'b0;
			end
			if (instrEnable && !instrBusy) begin
				retire(instrAddress, instrData);
			end
			if (probeState == stateHalt && !run && mgmt.writeEnable) begin
				applyWrite();
			end
		end
	end

endmodule

// File: sim/coreTb.sv
`timescale 1ns/1ps

module coreTb;
	import rv32Pkg::*;

	localparam int runLength = 200;
	localparam int stepCount = 8;
	localparam int memWords = 512;
	localparam int invalidSlot = 500;
	// Twenty cycles per instruction plus a margin for management traffic
	localparam int timeoutCycles = (runLength + stepCount + 1) * 20 + 3000;

	logic clk;
	logic rst;
	logic run;
	mgmtRequest_t mgmt;
	word_t mgmtReadData;
	word_t instrAddress;
	logic instrEnable;
	word_t instrData;
	logic instrBusy;
	coreState_e probeState;
	word_t probeProgramCounter;
	int checkerErrors;
	int readChecks;
	int acceptedFetches;
	int cycle = 0;
	word_t imem [0:memWords-1];
	logic busyPattern [0:255];

	rv32Core #(
		.resetVector(32'h0000_0000)
	) u_rv32Core (
		.clk(clk),
		.rst(rst),
		.run(run),
		.mgmt(mgmt),
		.mgmtReadData(mgmtReadData),
		.instrAddress(instrAddress),
		.instrEnable(instrEnable),
		.instrData(instrData),
		.instrBusy(instrBusy),
		.probeState(probeState),
		.probeProgramCounter(probeProgramCounter)
	);

	coreChecker #(
		.resetVector(32'h0000_0000)
	) u_coreChecker (
		.clk(clk),
		.rst(rst),
		.run(run),
		.mgmt(mgmt),
		.mgmtReadData(mgmtReadData),
		.instrAddress(instrAddress),
		.instrEnable(instrEnable),
		.instrData(instrData),
		.instrBusy(instrBusy),
		.probeState(probeState),
		.probeProgramCounter(probeProgramCounter),
		.errorCount(checkerErrors),
		.readChecks(readChecks),
		.acceptedFetches(acceptedFetches)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Memory answers 1 ns after each edge
	always @(posedge clk) begin
		#1;
		instrData = imem[instrAddress[10:2]];
		instrBusy = busyPattern[cycle % 256];
		cycle = cycle + 1;
	end

	initial begin
		repeat (timeoutCycles) @(posedge clk);
		$display("timeout: the test sequence did not finish within %0d cycles", timeoutCycles);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic word_t randomInstr();
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [6:0] badOp;
		word_t bits;
		int kind;
		rd = 5'($urandom);
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		f3 = 3'($urandom);
		bits = $urandom;
		kind = int'($urandom % 16);
		if (kind == 0) begin
			// Load, store, branch and jal are outside the subset
			case (bits[1:0])
				2'd0: badOp = 7'b0000011;
				2'd1: badOp = 7'b0100011;
				2'd2: badOp = 7'b1100011;
				default: badOp = 7'b1101111;
			endcase
			return {bits[31:7], badOp};
		end else if (kind < 3) begin
			return {bits[31:12], rd, opLui};
		end else if (kind < 4) begin
			return {bits[31:12], rd, opAuipc};
		end else if (kind < 10) begin
			if (f3 == 3'b001 || f3 == 3'b101) begin
				f7 = (f3 == 3'b101 && bits[0]) ? 7'h20 : 7'h00;
				return {f7, rs2, rs1, f3, rd, opImm};
			end
			return {bits[31:20], rs1, f3, rd, opImm};
		end
		f7 = ((f3 == 3'b000 || f3 == 3'b101) && bits[0]) ? 7'h20 : 7'h00;
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	task automatic writeMgmt(input mgmtAddr_t addr, input word_t data);
		mgmt.writeEnable = 1'b1;
		mgmt.byteSelect = 4'hf;
		mgmt.address = addr;
		mgmt.writeData = data;
		@(posedge clk);
		#1;
		mgmt = '0;
	endtask

	task automatic readMgmt(input mgmtAddr_t addr, input byteSel_t mask);
		mgmt.writeEnable = 1'b0;
		mgmt.byteSelect = mask;
		mgmt.address = addr;
		mgmt.writeData = '0;
		@(posedge clk);
		#1;
		mgmt = '0;
	endtask

	task automatic readAllRegs();
		for (int r = 0; r < 32; r++) begin
			readMgmt(mgmtRegBase + 16'(4 * r), 4'hf);
		end
	endtask

	task automatic waitHalt();
		@(posedge clk);
		#1;
		while (probeState != stateHalt) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic stepOnce();
		writeMgmt(mgmtPcStep, '0);
		waitHalt();
		readMgmt(mgmtPcSet, 4'hf);
		readAllRegs();
	endtask

	initial begin
		int runStart;
		int assertFails;
		void'($urandom(32'h495d_270d));
		for (int i = 0; i < memWords; i++) begin
			imem[i] = randomInstr();
		end
		// Fence lies outside the subset
		imem[invalidSlot] = {25'h0, 7'b0001111};
		for (int i = 0; i < 256; i++) begin
			busyPattern[i] = ($urandom % 4) == 0;
		end
		rst = 1'b1;
		run = 1'b0;
		mgmt = '0;
		instrData = '0;
		instrBusy = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int r = 0; r < 32; r++) begin
			writeMgmt(mgmtRegBase + 16'(4 * r), $urandom);
		end
		for (int k = 0; k < 48; k++) begin
			readMgmt(mgmtRegBase + 16'(4 * ($urandom % 32)), 4'(1 + $urandom % 15));
		end
		for (int k = 0; k < 16; k++) begin
			readMgmt(16'($urandom), 4'(1 + $urandom % 15));
		end
		readMgmt(mgmtPcSet, 4'hf);

		writeMgmt(mgmtPcSet, 32'h0000_0100);
		runStart = acceptedFetches;
		run = 1'b1;
		// Ignored once run is high
		writeMgmt(mgmtRegBase + 16'h0014, 32'hdead_beef);
		writeMgmt(mgmtPcSet, 32'h0000_0040);
		writeMgmt(mgmtRegBase + 16'h0018, 32'h0bad_f00d);
		while (acceptedFetches - runStart < runLength) begin
			@(posedge clk);
			#1;
		end
		run = 1'b0;
		waitHalt();
		readAllRegs();
		readMgmt(mgmtPcSet, 4'hf);
		readMgmt(mgmtStatus, 4'hf);

		for (int s = 0; s < stepCount; s++) begin
			stepOnce();
		end

		writeMgmt(mgmtStatus, '0);
		readMgmt(mgmtStatus, 4'hf);
		writeMgmt(mgmtPcSet, 32'(invalidSlot * 4));
		stepOnce();
		readMgmt(mgmtStatus, 4'hf);
		writeMgmt(mgmtStatus, '0);
		readMgmt(mgmtStatus, 4'hf);

		assertFails = u_rv32Core.u_rv32CoreAssertions.failCount;
		$display("errors: checker %0d, assertions %0d (%0d reads, %0d fetches seen)",
			checkerErrors, assertFails, readChecks, acceptedFetches);
		if (checkerErrors == 0 && assertFails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: all.f
logic/rv32Pkg.sv
logic/managementPort.sv
logic/instructionFetch.sv
logic/executeStage.sv
logic/registerFile.sv
logic/rv32Core.sv
sim/rv32Core_assertions.sv
sim/coreChecker.sv
sim/coreTb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST ?= all.f
TB_TOP ?= coreTb
RTL_TOP ?= rv32Core
BUILD_DIR ?= obj_dir
LOG ?= sim.log
ERROR_LIMIT ?= 1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) +verilator+error+limit+$(ERROR_LIMIT) 2>&1 | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
